// File: Makefile
SOURCES := $(shell grep -v '^+' compile.f)

.PHONY: all run clean

all: run

obj_dir/Vfpu_tb: compile.f $(SOURCES)
	verilator --binary --timing --top-module fpu_tb -f compile.f -o Vfpu_tb

run: obj_dir/Vfpu_tb
	./obj_dir/Vfpu_tb | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/fpu_tb.sv
module fpu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import fpu_pkg::*;

  localparam int ADDR_W = 5;
  localparam int APB_TIMEOUT = 16;   // Cycles allowed for pready

  logic              clk;
  logic              arst_n;
  logic [ADDR_W-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  float_t            pwdata;
  float_t            prdata;
  logic              pready;
  logic              pslverr;

  fpu_top #(
    .ADDR_W (ADDR_W)
  ) fpu_top_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  // Exact single to double with subnormals read as zero
  function automatic real float_to_real(float_t x);
    if (x[30:23] == 8'hff) return $bitstoreal({x[31], 11'h7ff, x[22:0], 29'd0});
    if (x[30:23] == 8'h00) return $bitstoreal({x[31], 63'd0});
    return $bitstoreal({x[31], 11'(x[30:23]) + 11'd896, x[22:0], 29'd0});
  endfunction

  // Double to single by nearest even with tiny results flushed to zero
  function automatic float_t real_to_float(real r);
    logic [63:0] d;
    logic        up;
    logic [23:0] keep;
    int          e;
    d = $realtobits(r);
    if (d[62:52] == 11'h7ff) return (d[51:0] != '0) ? QNAN : {d[63], 8'hff, 23'd0};
    if (d[62:0] == '0) return {d[63], 31'd0};
    up   = d[28] & (d[29] | (|d[27:0]));
    keep = {1'b0, d[51:29]} + 24'(up);
    e    = int'(d[62:52]) - 1023 + 127 + int'(keep[23]);
    if (e >= 255) return {d[63], 8'hff, 23'd0};
    if (e <= 0) return {d[63], 31'd0};
    return {d[63], e[7:0], keep[22:0]};
  endfunction

  function automatic float_t fp_ref(fp_op_e op, float_t a, float_t b);
    real ra;
    real rb;
    ra = float_to_real(a);
    rb = float_to_real(b);
    case (op)
      OP_ADD: return real_to_float(ra + rb);
      OP_SUB: return real_to_float(ra - rb);
      OP_MUL: return real_to_float(ra * rb);
      OP_I2F: return real_to_float($itor($signed(a)));
      OP_F2I: begin
        if (ra != ra) return 32'h7fff_ffff;             // NaN
        if (ra >= 2147483648.0) return 32'h7fff_ffff;
        if (ra < -2147483648.0) return 32'h8000_0000;
        return float_t'($rtoi(ra));                    // Toward zero
      end
      OP_EQ: return {31'd0, ra == rb};
      OP_LT: return {31'd0, ra < rb};
      OP_LE: return {31'd0, ra <= rb};
      OP_CLASS: begin
        if (a[30:23] == 8'hff) return (a[22:0] == '0) ? 32'd0 : 32'd7;
        if (a[30:23] == 8'h00 && a[22:0] == '0) return a[31] ? 32'd3 : 32'd4;
        if (a[30:23] == 8'h00) return a[31] ? 32'd2 : 32'd5;
        return a[31] ? 32'd1 : 32'd6;
      end
      default: return a;   // Undefined op echoes a
    endcase
  endfunction

  function automatic float_t random_normal(int lo, int hi);
    float_t f;
    int     span;
    span      = hi - lo + 1;
    f[31]     = 1'($urandom % 2);
    f[30:23]  = 8'(lo + int'($urandom % span));
    f[22:0]   = 23'($urandom);
    return f;
  endfunction

  //////////////////////////////////////////////////
  // Checking and APB tasks
  //////////////////////////////////////////////////
  task automatic fail_run(string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("MISMATCH %s expected %08h actual %08h", name, expected, actual));
    end
  endtask

  task automatic apb_transfer(input logic write, input logic [31:0] addr, input float_t wdata,
                              output float_t rdata, output logic slverr);
    int waits;
    waits = 0;
    @(posedge clk);
    paddr   <= addr[ADDR_W-1:0];
    pwrite  <= write;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;   // Access phase
    @(negedge clk);
    while (!pready) begin
      waits++;
      if (waits > APB_TIMEOUT) fail_run("APB transfer timed out, pready never rose");
      @(posedge clk);
      @(negedge clk);
    end
    rdata  = prdata;
    slverr = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_write(logic [31:0] addr, float_t data, logic expect_err);
    float_t unused;
    logic   err;
    apb_transfer(1'b1, addr, data, unused, err);
    check_value($sformatf("pslverr on write to %0h", addr), 32'(expect_err), 32'(err));
  endtask

  task automatic apb_read(input logic [31:0] addr, input logic expect_err, output float_t data);
    logic err;
    apb_transfer(1'b0, addr, '0, data, err);
    check_value($sformatf("pslverr on read of %0h", addr), 32'(expect_err), 32'(err));
  endtask

  task automatic run_op(string name, fp_op_e op, float_t a, float_t b);
    float_t got;
    apb_write(REG_A, a, 1'b0);
    apb_write(REG_B, b, 1'b0);
    apb_write(REG_OP, {28'd0, op}, 1'b0);
    apb_read(REG_RESULT, 1'b0, got);   // Result is ready before this read
    check_value(name, fp_ref(op, a, b), got);
  endtask

  task automatic compare_all(string name, float_t a, float_t b);
    run_op({name, " eq"}, OP_EQ, a, b);
    run_op({name, " lt"}, OP_LT, a, b);
    run_op({name, " le"}, OP_LE, a, b);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////
  initial begin
    float_t a;
    float_t b;
    float_t got;
    float_t class_vals [9];
    void'($urandom(70));
    arst_n  <= 1'b0;
    paddr   <= '0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    pwdata  <= '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    apb_read(REG_STATUS, 1'b0, got);
    check_value("status after reset", 32'd0, got);
    apb_read(REG_RESULT, 1'b0, got);
    check_value("result after reset", 32'd0, got);

    // Exponents 100..154 keep every sum, difference and product normal
    for (int i = 0; i < 200; i++) begin
      a = random_normal(100, 154);
      b = random_normal(100, 154);
      case (i % 3)
        0:       run_op("random add", OP_ADD, a, b);
        1:       run_op("random sub", OP_SUB, a, b);
        default: run_op("random mul", OP_MUL, a, b);
      endcase
    end
    run_op("exact cancel", OP_SUB, a, a);

    for (int i = 0; i < 30; i++) begin
      run_op("random i2f", OP_I2F, $urandom, '0);
      run_op("random f2i", OP_F2I, random_normal(100, 156), '0);
    end
    run_op("i2f tie to even", OP_I2F, 32'd16777217, '0);
    run_op("i2f tie round up", OP_I2F, 32'd16777219, '0);
    run_op("i2f most negative", OP_I2F, 32'h8000_0000, '0);
    run_op("f2i saturate 1e10", OP_F2I, 32'h5015_02f9, '0);
    run_op("f2i saturate -1e10", OP_F2I, 32'hd015_02f9, '0);

    for (int i = 0; i < 20; i++) begin
      a = random_normal(120, 134);
      b = (i % 2 == 0) ? random_normal(120, 134) : {1'($urandom % 2), a[30:23], 23'($urandom)};
      compare_all("random pair", a, b);
      compare_all("equal pair", a, a);
    end
    compare_all("pos zero neg zero", 32'h0000_0000, 32'h8000_0000);
    compare_all("neg zero pos zero", 32'h8000_0000, 32'h0000_0000);
    compare_all("nan left", QNAN, 32'h3f80_0000);
    compare_all("nan right", 32'h3f80_0000, 32'h7f80_0001);

    class_vals = '{32'h7f80_0000, 32'hff80_0000, 32'hbf80_0000, 32'h8000_0001, 32'h8000_0000,
                   32'h0000_0000, 32'h0040_0000, 32'h3f80_0000, 32'h7fc0_0000};
    foreach (class_vals[i]) begin
      run_op("class", OP_CLASS, class_vals[i], '0);
    end
    run_op("inf plus neg inf", OP_ADD, 32'h7f80_0000, 32'hff80_0000);
    run_op("zero times inf", OP_MUL, 32'h0000_0000, 32'h7f80_0000);
    run_op("max times two", OP_MUL, 32'h7f7f_ffff, 32'h4000_0000);

    run_op("undefined op", fp_op_e'(4'h1), 32'h1234_5678, 32'h3f80_0000);
    apb_read(REG_STATUS, 1'b0, got);
    check_value("status err bit", 32'd2, got);
    run_op("valid op after error", OP_ADD, 32'h3f80_0000, 32'h3f80_0000);
    apb_read(REG_STATUS, 1'b0, got);
    check_value("status err cleared", 32'd0, got);

    apb_write(REG_RESULT, 32'hdead_beef, 1'b1);
    apb_write(REG_STATUS, 32'h0000_0003, 1'b1);
    apb_write(32'h14, 32'h0000_0001, 1'b1);    // Unmapped
    apb_read(32'h18, 1'b1, got);
    apb_read(REG_RESULT, 1'b0, got);
    check_value("result kept after bad write", 32'h4000_0000, got);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: common/fpu_pkg.sv
package fpu_pkg;

  typedef logic [31:0] float_t;
  typedef logic [7:0]  fp_exp_t;   // Biased exponent
  typedef logic [22:0] fp_man_t;   // Fraction without hidden bit

  typedef struct packed {
    logic    sign;
    fp_exp_t exp;
    fp_man_t man;
  } fp_fields_t;

  typedef enum logic [3:0] {
    OP_ADD   = 4'b0000,
    OP_MUL   = 4'b0010,
    OP_CLASS = 4'b0011,
    OP_I2F   = 4'b0100,
    OP_F2I   = 4'b0101,
    OP_EQ    = 4'b1100,
    OP_LT    = 4'b1101,
    OP_LE    = 4'b1110,
    OP_SUB   = 4'b1111
  } fp_op_e;

  typedef enum logic [2:0] {ZERO, SUBNORMAL, INF, NAN, NORMAL} fp_type_e;

  // Class codes for OP_CLASS
  localparam float_t CLASS_INF        = 32'd0;
  localparam float_t CLASS_NEG_NORMAL = 32'd1;
  localparam float_t CLASS_NEG_SUB    = 32'd2;
  localparam float_t CLASS_NEG_ZERO   = 32'd3;
  localparam float_t CLASS_POS_ZERO   = 32'd4;
  localparam float_t CLASS_POS_SUB    = 32'd5;
  localparam float_t CLASS_POS_NORMAL = 32'd6;
  localparam float_t CLASS_NAN        = 32'd7;

  localparam float_t QNAN = 32'h7fc0_0000;  // Canonical NaN

  typedef struct packed {
    float_t a;
    float_t b;
    fp_op_e op;
  } fp_req_t;

  typedef struct packed {
    float_t result;
    logic   err;
  } fp_rsp_t;

  // Register word addresses
  localparam logic [31:0] REG_A      = 32'h00;
  localparam logic [31:0] REG_B      = 32'h04;
  localparam logic [31:0] REG_OP     = 32'h08;
  localparam logic [31:0] REG_RESULT = 32'h0c;
  localparam logic [31:0] REG_STATUS = 32'h10;

  function automatic fp_type_e fp_type_of(float_t x);
    fp_fields_t f;
    f = x;
    if (f.exp == '0) begin
      return (f.man == '0) ? ZERO : SUBNORMAL;
    end
    if (f.exp == '1) begin
      return (f.man == '0) ? INF : NAN;
    end
    return NORMAL;
  endfunction

endpackage

// File: compile.f
common/fpu_pkg.sv
fp_adder/fp_adder.sv
fp_multiplier/fp_multiplier.sv
source/fp_convert.sv
source/fp_alu.sv
source/fpu_apb_regs.sv
source/fpu_top.sv
bench/fpu_tb.sv

// File: fp_adder/fp_adder.sv
module fp_adder (
  input  logic            clk,
  input  logic            arst_n,
  input  fpu_pkg::float_t a,
  input  fpu_pkg::float_t b,
  input  logic            subtract,
  output fpu_pkg::float_t sum
);
  import fpu_pkg::*;

  fp_fields_t        fa;
  fp_fields_t        fb;         // b with its sign flipped on subtract
  fp_type_e          ta;
  fp_type_e          tb;
  logic [30:0]       mag_a;
  logic [30:0]       mag_b;
  logic              swap;
  logic [30:0]       big_mag;
  logic [30:0]       small_mag;
  logic              sign_big;
  logic              sign_small;
  logic              eff_sub;
  fp_exp_t           exp_big;
  fp_exp_t           exp_diff;
  logic [23:0]       man_big;
  logic [23:0]       man_small;
  logic [49:0]       shifted;
  logic [26:0]       big_ext;
  logic [26:0]       small_ext;   // Mantissa, guard, round, sticky
  logic [27:0]       raw;
  logic [4:0]        lz;
  logic [26:0]       norm;
  logic signed [9:0] exp_norm;
  logic signed [9:0] exp_fin;
  logic              round_up;
  logic [24:0]       rounded;
  float_t            sum_d;

  assign fa = a;
  assign fb = {b[31] ^ subtract, b[30:0]};
  assign ta = fp_type_of(a);
  assign tb = fp_type_of(b);

  //////////////////////////////////////////////////
  // Order by magnitude and align
  //////////////////////////////////////////////////
  assign mag_a = (ta == NORMAL) ? a[30:0] : '0;  // Subnormal treated as zero
  assign mag_b = (tb == NORMAL) ? b[30:0] : '0;

  assign swap       = (mag_b > mag_a);
  assign big_mag    = swap ? mag_b : mag_a;
  assign small_mag  = swap ? mag_a : mag_b;
  assign sign_big   = swap ? fb.sign : fa.sign;
  assign sign_small = swap ? fa.sign : fb.sign;
  assign eff_sub    = sign_big ^ sign_small;

  assign exp_big   = big_mag[30:23];
  assign exp_diff  = big_mag[30:23] - small_mag[30:23];
  assign man_big   = {|big_mag, big_mag[22:0]};    // Hidden bit set if nonzero
  assign man_small = {|small_mag, small_mag[22:0]};

  assign shifted   = {man_small, 26'd0} >> exp_diff;
  assign small_ext = {shifted[49:24], |shifted[23:0]};
  assign big_ext   = {man_big, 3'b000};

  assign raw = eff_sub ? {1'b0, big_ext} - {1'b0, small_ext}
                       : {1'b0, big_ext} + {1'b0, small_ext};

  //////////////////////////////////////////////////
  // Normalize, round, special cases
  //////////////////////////////////////////////////
  always_comb begin
    lz = 5'd27;
    for (int i = 0; i < 27; i++) begin
      if (raw[i]) lz = 5'(26 - i);   // Highest one wins
    end

    if (raw[27]) begin
      norm     = {raw[27:2], raw[1] | raw[0]};  // Carry out folds the lost bit into sticky
      exp_norm = $signed({2'b00, exp_big}) + 10'sd1;
    end else begin
      norm     = raw[26:0] << lz;
      exp_norm = $signed({2'b00, exp_big}) - $signed({5'd0, lz});
    end

    // Nearest even
    round_up = norm[2] & (norm[3] | norm[1] | norm[0]);
    rounded  = {1'b0, norm[26:3]} + 25'(round_up);
    exp_fin  = exp_norm + $signed({9'd0, rounded[24]});

    if (ta == NAN || tb == NAN || (ta == INF && tb == INF && fa.sign != fb.sign)) begin
      sum_d = QNAN;
    end else if (ta == INF) begin
      sum_d = {fa.sign, 8'hff, 23'd0};
    end else if (tb == INF) begin
      sum_d = {fb.sign, 8'hff, 23'd0};
    end else if (raw == '0) begin
      sum_d = {fa.sign & fb.sign, 31'd0};  // Only -0 + -0 keeps the sign
    end else if (exp_fin >= 10'sd255) begin
      sum_d = {sign_big, 8'hff, 23'd0};
    end else if (exp_fin <= 10'sd0) begin
      sum_d = {sign_big, 31'd0};           // Flush to zero
    end else begin
      sum_d = {sign_big, exp_fin[7:0], rounded[22:0]};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sum <= '0;
    end else begin
      sum <= sum_d;
    end
  end

endmodule

// File: fp_multiplier/fp_multiplier.sv
module fp_multiplier (
  input  fpu_pkg::float_t a,
  input  fpu_pkg::float_t b,
  output fpu_pkg::float_t product
);
  import fpu_pkg::*;

  fp_fields_t        fa;
  fp_fields_t        fb;
  fp_type_e          ta;
  fp_type_e          tb;
  logic              sign;
  logic              a_zero;
  logic              b_zero;
  logic [47:0]       man_prod;
  logic [22:0]       man_n;
  logic              guard;
  logic              sticky;
  logic              round_up;
  logic [24:0]       rounded;
  logic signed [9:0] exp_sum;
  logic signed [9:0] exp_fin;

  assign fa     = a;
  assign fb     = b;
  assign ta     = fp_type_of(a);
  assign tb     = fp_type_of(b);
  assign sign   = fa.sign ^ fb.sign;
  assign a_zero = (ta == ZERO) || (ta == SUBNORMAL);
  assign b_zero = (tb == ZERO) || (tb == SUBNORMAL);

  assign man_prod = {1'b1, fa.man} * {1'b1, fb.man};  // Product in [1, 4)

  always_comb begin
    // At most one position of normalization
    if (man_prod[47]) begin
      man_n  = man_prod[46:24];
      guard  = man_prod[23];
      sticky = |man_prod[22:0];
    end else begin
      man_n  = man_prod[45:23];
      guard  = man_prod[22];
      sticky = |man_prod[21:0];
    end
    exp_sum  = $signed({2'b00, fa.exp}) + $signed({2'b00, fb.exp}) - 10'sd127
               + $signed({9'd0, man_prod[47]});
    round_up = guard & (sticky | man_n[0]);
    rounded  = {2'b01, man_n} + 25'(round_up);
    exp_fin  = exp_sum + $signed({9'd0, rounded[24]});

    if (ta == NAN || tb == NAN || (a_zero && tb == INF) || (b_zero && ta == INF)) begin
      product = QNAN;
    end else if (ta == INF || tb == INF) begin
      product = {sign, 8'hff, 23'd0};
    end else if (a_zero || b_zero) begin
      product = {sign, 31'd0};
    end else if (exp_fin >= 10'sd255) begin
      product = {sign, 8'hff, 23'd0};   // Overflow
    end else if (exp_fin <= 10'sd0) begin
      product = {sign, 31'd0};          // Underflow
    end else begin
      product = {sign, exp_fin[7:0], rounded[22:0]};
    end
  end

endmodule

// File: source/fp_alu.sv
module fp_alu (
  input  logic             clk,
  input  logic             arst_n,
  input  fpu_pkg::fp_req_t req,
  input  logic             start,
  output fpu_pkg::fp_rsp_t rsp,
  output logic             rsp_valid
);
  import fpu_pkg::*;

  fp_fields_t fa;
  fp_fields_t fb;
  fp_type_e   ta;
  fp_type_e   tb;
  float_t     sum;        // Already registered inside the adder
  float_t     product;
  float_t     to_float;
  float_t     to_int;
  float_t     class_code;
  logic       any_nan;
  logic       both_zero;
  logic       mag_lt;
  logic       mag_gt;
  logic       eq;
  logic       lt;

  fp_op_e     op_q;
  float_t     a_q;
  float_t     product_q;
  float_t     to_float_q;
  float_t     to_int_q;
  float_t     class_q;
  logic       eq_q;
  logic       lt_q;
  logic       le_q;

  assign fa = req.a;
  assign fb = req.b;
  assign ta = fp_type_of(req.a);
  assign tb = fp_type_of(req.b);

  fp_adder fp_adder_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .a        (req.a),
    .b        (req.b),
    .subtract (req.op == OP_SUB),
    .sum      (sum)
  );

  fp_multiplier fp_multiplier_inst (
    .a       (req.a),
    .b       (req.b),
    .product (product)
  );

  fp_convert fp_convert_inst (
    .a        (req.a),
    .to_float (to_float),
    .to_int   (to_int)
  );

  //////////////////////////////////////////////////
  // Compare
  //////////////////////////////////////////////////
  assign any_nan   = (ta == NAN) || (tb == NAN);
  assign both_zero = (ta == ZERO) && (tb == ZERO);   // +0 equals -0
  assign mag_lt    = (fa.exp < fb.exp) || (fa.exp == fb.exp && fa.man < fb.man);
  assign mag_gt    = (fb.exp < fa.exp) || (fa.exp == fb.exp && fb.man < fa.man);
  assign eq        = !any_nan && (req.a == req.b || both_zero);

  always_comb begin
    if (any_nan || both_zero) begin
      lt = 1'b0;
    end else if (fa.sign != fb.sign) begin
      lt = fa.sign;
    end else begin
      lt = fa.sign ? mag_gt : mag_lt;   // Negative operands reverse the order
    end
  end

  always_comb begin
    case (ta)
      INF:       class_code = CLASS_INF;
      NORMAL:    class_code = fa.sign ? CLASS_NEG_NORMAL : CLASS_POS_NORMAL;
      SUBNORMAL: class_code = fa.sign ? CLASS_NEG_SUB : CLASS_POS_SUB;
      ZERO:      class_code = fa.sign ? CLASS_NEG_ZERO : CLASS_POS_ZERO;
      default:   class_code = CLASS_NAN;
    endcase
  end

  //////////////////////////////////////////////////
  // Result stage
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_q      <= OP_ADD;
      rsp_valid <= 1'b0;
    end else begin
      op_q      <= req.op;
      rsp_valid <= start;
    end
  end

  always_ff @(posedge clk) begin
    a_q        <= req.a;
    product_q  <= product;
    to_float_q <= to_float;
    to_int_q   <= to_int;
    class_q    <= class_code;
    eq_q       <= eq;
    lt_q       <= lt;
    le_q       <= lt | eq;
  end

  always_comb begin
    rsp.err = 1'b0;
    case (op_q)
      OP_ADD, OP_SUB: rsp.result = sum;
      OP_MUL:         rsp.result = product_q;
      OP_I2F:         rsp.result = to_float_q;
      OP_F2I:         rsp.result = to_int_q;
      OP_EQ:          rsp.result = {31'd0, eq_q};
      OP_LT:          rsp.result = {31'd0, lt_q};
      OP_LE:          rsp.result = {31'd0, le_q};
      OP_CLASS:       rsp.result = class_q;
      default: begin
        rsp.result = a_q;   // Undefined op echoes a
        rsp.err    = 1'b1;
      end
    endcase
  end

endmodule

// File: source/fp_convert.sv
module fp_convert (
  input  fpu_pkg::float_t a,
  output fpu_pkg::float_t to_float,
  output fpu_pkg::float_t to_int
);
  import fpu_pkg::*;

  fp_fields_t  fa;
  fp_type_e    ta;
  logic [31:0] mag;        // Integer magnitude
  logic [4:0]  lead;
  logic [31:0] norm;
  logic        round_up;
  logic [24:0] rounded;
  fp_exp_t     exp_f;
  logic [4:0]  shift;
  logic [63:0] ext;
  logic [31:0] trunc;

  assign fa = a;
  assign ta = fp_type_of(a);

  //////////////////////////////////////////////////
  // Signed integer to float
  //////////////////////////////////////////////////
  always_comb begin
    mag  = a[31] ? -a : a;
    lead = '0;
    for (int i = 0; i < 32; i++) begin
      if (mag[i]) lead = 5'(i);
    end
    norm     = mag << (5'd31 - lead);   // Leading one to bit 31
    round_up = norm[7] & (norm[8] | (|norm[6:0]));
    rounded  = {1'b0, norm[31:8]} + 25'(round_up);
    exp_f    = 8'd127 + 8'(lead) + 8'(rounded[24]);

    if (mag == '0) begin
      to_float = '0;
    end else begin
      to_float = {a[31], exp_f, rounded[22:0]};
    end
  end

  //////////////////////////////////////////////////
  // Float to signed integer toward zero
  //////////////////////////////////////////////////
  always_comb begin
    shift = 5'(fa.exp - 8'd127);
    ext   = 64'({1'b1, fa.man}) << shift;
    trunc = ext[54:23];               // Fraction bits dropped

    if (ta == NAN) begin
      to_int = 32'h7fff_ffff;
    end else if (fa.exp < 8'd127) begin
      to_int = '0;                    // Magnitude below one truncates to zero
    end else if (fa.exp >= 8'd158) begin
      to_int = fa.sign ? 32'h8000_0000 : 32'h7fff_ffff;
    end else begin
      to_int = fa.sign ? -trunc : trunc;
    end
  end

endmodule

// File: source/fpu_apb_regs.sv
module fpu_apb_regs #(
  parameter int ADDR_W = 5
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [ADDR_W-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  fpu_pkg::float_t   pwdata,
  output fpu_pkg::float_t   prdata,
  output logic              pready,
  output logic              pslverr,
  output fpu_pkg::fp_req_t  req,
  output logic              start,
  input  fpu_pkg::fp_rsp_t  rsp,
  input  logic              rsp_valid
);
  import fpu_pkg::*;

  logic [31:0] addr;
  logic        access;
  logic        hit_a;
  logic        hit_b;
  logic        hit_op;
  logic        hit_result;
  logic        hit_status;
  logic        mapped;
  logic        wr_en;
  fp_req_t     req_q;
  fp_req_t     req_d;
  float_t      result_q;
  logic        busy_q;
  logic        err_q;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////
  assign addr       = 32'(paddr);
  assign access     = psel & penable;
  assign hit_a      = (addr == REG_A);
  assign hit_b      = (addr == REG_B);
  assign hit_op     = (addr == REG_OP);
  assign hit_result = (addr == REG_RESULT);
  assign hit_status = (addr == REG_STATUS);
  assign mapped     = hit_a | hit_b | hit_op | hit_result | hit_status;

  assign wr_en   = access & pwrite & (hit_a | hit_b | hit_op);
  assign pready  = 1'b1;   // No wait states
  assign pslverr = access & (~mapped | (pwrite & (hit_result | hit_status)));
  assign start   = wr_en & hit_op;

  // ALU sees the new value in the access cycle itself
  always_comb begin
    req_d = req_q;
    if (wr_en && hit_a) req_d.a = pwdata;
    if (wr_en && hit_b) req_d.b = pwdata;
    if (start) req_d.op = fp_op_e'(pwdata[3:0]);
  end

  assign req = req_d;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_q    <= '0;
      result_q <= '0;
      busy_q   <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      req_q <= req_d;
      if (rsp_valid) begin
        result_q <= rsp.result;
        err_q    <= rsp.err;
      end
      if (start) begin
        busy_q <= 1'b1;
      end else if (rsp_valid) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Read mux
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (hit_a)           prdata = req_q.a;
      else if (hit_b)      prdata = req_q.b;
      else if (hit_op)     prdata = {28'd0, req_q.op};
      else if (hit_result) prdata = result_q;
      else if (hit_status) prdata = {30'd0, err_q, busy_q};
    end
  end

endmodule

// File: source/fpu_top.sv
module fpu_top #(
  parameter int ADDR_W = 5
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [ADDR_W-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  fpu_pkg::float_t   pwdata,
  output fpu_pkg::float_t   prdata,
  output logic              pready,
  output logic              pslverr
);
  import fpu_pkg::*;

  fp_req_t req;
  logic    start;
  fp_rsp_t rsp;
  logic    rsp_valid;

  fpu_apb_regs #(
    .ADDR_W (ADDR_W)
  ) fpu_apb_regs_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .req       (req),
    .start     (start),
    .rsp       (rsp),
    .rsp_valid (rsp_valid)
  );

  fp_alu fp_alu_inst (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .start     (start),
    .rsp       (rsp),
    .rsp_valid (rsp_valid)
  );

endmodule
